//--- common/trace_cfg_pkg.sv
// widths and sizes shared by every stage of the trace packet emitter
// referenced by scoped name, never imported
package trace_cfg_pkg;

    // address and tval width
    localparam int unsigned XLEN             = 64;
    localparam int unsigned CAUSE_LEN        = 5;
    localparam int unsigned PRIV_LEN         = 2;
    localparam int unsigned BRANCH_COUNT_LEN = 5;
    // branch map width, also the count at which the map is full
    localparam int unsigned BRANCH_MAP_LEN   = 31;
    localparam int unsigned IRDEPTH_LEN      = 8;
    localparam int unsigned KEEP_BITS_LEN    = 7;
    // kept byte count, 0 to 8
    localparam int unsigned KEEP_BYTES_LEN   = 4;
    localparam int unsigned PAYLOAD_LEN      = 144;
    // payload minus the 4 bits of header room
    localparam int unsigned BODY_LEN         = 140;
    localparam int unsigned USED_BITS_LEN    = 9;
    // payload length in bytes
    localparam int unsigned P_LEN            = 5;

endpackage

//--- common/trace_pkt_pkg.sv
// packet level encodings of the branch trace encoder
// format, subformat, packet type and support option fields
package trace_pkt_pkg;

    typedef enum logic [1:0] {
        F_OPT_EXT    = 2'd0,
        F_DIFF_DELTA = 2'd1,
        F_ADDR_ONLY  = 2'd2,
        F_SYNC       = 2'd3
    } format_e;

    // subformats of format 3
    typedef enum logic [1:0] {
        SF_START   = 2'd0,
        SF_TRAP    = 2'd1,
        SF_CONTEXT = 2'd2,
        SF_SUPPORT = 2'd3
    } sync_subformat_e;

    typedef enum logic [2:0] {
        PT_NONE, PT_F1, PT_F2, PT_F3SF0, PT_F3SF1, PT_F3SF2, PT_F3SF3
    } packet_type_e;

    // qualification status carried in support packets
    typedef enum logic [1:0] {
        QS_NO_CHANGE, QS_ENDED_REP, QS_TRACE_LOST, QS_ENDED_NTR
    } qual_status_e;

    typedef enum logic [2:0] {
        IO_DELTA_ADDR, IO_FULL_ADDR, IO_IMPLICIT_EXC, IO_SIJUMP, IO_IMPLICIT_RET
    } ioptions_e;

endpackage

//--- emitter/packet_decoder.sv
// decode stage, turns format and subformat into packet type and control flags
// also does the lc/tc field selection and the kept byte count
module packet_decoder (
    input  logic                                      valid_i,
    input  trace_pkt_pkg::format_e                    packet_format_i,
    input  trace_pkt_pkg::sync_subformat_e            packet_f_sync_subformat_i,
    input  logic                                      lc_tc_mux_i,
    input  logic                                      thaddr_i,
    input  logic                                      tc_branch_i,
    input  logic                                      tc_branch_taken_i,
    input  logic [trace_cfg_pkg::CAUSE_LEN-1:0]       lc_cause_i,
    input  logic [trace_cfg_pkg::CAUSE_LEN-1:0]       tc_cause_i,
    input  logic [trace_cfg_pkg::XLEN-1:0]            lc_tval_i,
    input  logic [trace_cfg_pkg::XLEN-1:0]            tc_tval_i,
    input  logic                                      lc_interrupt_i,
    input  logic                                      tc_interrupt_i,
    input  logic [trace_cfg_pkg::XLEN-1:2]            tc_tvec_i,
    input  logic [trace_cfg_pkg::XLEN-1:0]            lc_epc_i,
    input  logic [trace_cfg_pkg::KEEP_BITS_LEN-1:0]   keep_bits_i,
    output logic                                      emit_o,
    output logic                                      update_latest_o,
    output logic                                      flush_o,
    output trace_pkt_pkg::packet_type_e               pkt_type_o,
    output logic                                      branch_bit_o,
    output logic [trace_cfg_pkg::CAUSE_LEN-1:0]       sel_cause_o,
    output logic [trace_cfg_pkg::XLEN-1:0]            sel_tval_o,
    output logic                                      sel_interrupt_o,
    output logic [trace_cfg_pkg::XLEN-1:0]            trap_addr_o,
    output logic [trace_cfg_pkg::KEEP_BYTES_LEN-1:0]  keep_bytes_o
);

    // ceil(keep_bits / 8), up to 16 before the clamp
    logic [4:0] bytes_raw;

    // low when a taken branch happened this cycle
    assign branch_bit_o    = ~(tc_branch_i & tc_branch_taken_i);
    assign sel_cause_o     = lc_tc_mux_i ? tc_cause_i : lc_cause_i;
    assign sel_tval_o      = lc_tc_mux_i ? tc_tval_i : lc_tval_i;
    assign sel_interrupt_o = lc_tc_mux_i ? tc_interrupt_i : lc_interrupt_i;
    // trap handler base is word aligned
    assign trap_addr_o     = thaddr_i ? {tc_tvec_i, 2'b00} : lc_epc_i;

    assign bytes_raw    = 5'((8'(keep_bits_i) + 8'd7) >> 3);
    assign keep_bytes_o = (bytes_raw > 5'd8) ? 4'd8 : bytes_raw[3:0];

    // format 0 is not emitted
    assign emit_o  = valid_i && (packet_format_i != trace_pkt_pkg::F_OPT_EXT);
    assign flush_o = valid_i && (packet_format_i == trace_pkt_pkg::F_DIFF_DELTA);

    always_comb begin
        pkt_type_o      = trace_pkt_pkg::PT_NONE;
        update_latest_o = 1'b0;
        if (valid_i) begin
            case (packet_format_i)
                trace_pkt_pkg::F_SYNC: begin
                    case (packet_f_sync_subformat_i)
                        trace_pkt_pkg::SF_START: begin
                            pkt_type_o      = trace_pkt_pkg::PT_F3SF0;
                            update_latest_o = 1'b1;
                        end
                        trace_pkt_pkg::SF_TRAP: begin
                            pkt_type_o      = trace_pkt_pkg::PT_F3SF1;
                            update_latest_o = 1'b1;
                        end
                        trace_pkt_pkg::SF_CONTEXT: pkt_type_o = trace_pkt_pkg::PT_F3SF2;
                        default: pkt_type_o = trace_pkt_pkg::PT_F3SF3;
                    endcase
                end
                trace_pkt_pkg::F_ADDR_ONLY: begin
                    pkt_type_o      = trace_pkt_pkg::PT_F2;
                    update_latest_o = 1'b1;
                end
                trace_pkt_pkg::F_DIFF_DELTA: begin
                    pkt_type_o      = trace_pkt_pkg::PT_F1;
                    update_latest_o = 1'b1;
                end
                default: ;
            endcase
        end
    end

endmodule

//--- emitter/sync_field_builder.sv
// execute stage for format 3, lays out the body above the 4 header bits
// addresses are cut down to the kept low bytes
module sync_field_builder (
    input  trace_pkt_pkg::sync_subformat_e            subformat_i,
    input  logic                                      branch_bit_i,
    input  logic [trace_cfg_pkg::PRIV_LEN-1:0]        tc_priv_i,
    input  logic [trace_cfg_pkg::XLEN-1:0]            tc_iaddr_i,
    input  logic [trace_cfg_pkg::CAUSE_LEN-1:0]       sel_cause_i,
    input  logic                                      sel_interrupt_i,
    input  logic                                      thaddr_i,
    input  logic [trace_cfg_pkg::XLEN-1:0]            trap_addr_i,
    input  logic [trace_cfg_pkg::XLEN-1:0]            sel_tval_i,
    input  logic                                      tc_ienable_i,
    input  logic                                      encoder_mode_i,
    input  trace_pkt_pkg::qual_status_e               qual_status_i,
    input  trace_pkt_pkg::ioptions_e                  ioptions_i,
    input  logic [trace_cfg_pkg::KEEP_BYTES_LEN-1:0]  keep_bytes_i,
    output logic [trace_cfg_pkg::BODY_LEN-1:0]        body_o,
    output logic [trace_cfg_pkg::USED_BITS_LEN-1:0]   body_bits_o
);

    logic [6:0]                                         addr_bits;
    logic [trace_cfg_pkg::XLEN-1:0]                     keep_mask;
    // branch, priv, cause, interrupt, thaddr
    logic [trace_cfg_pkg::CAUSE_LEN+trace_cfg_pkg::PRIV_LEN+2:0] trap_head;

    assign addr_bits = {keep_bytes_i, 3'b000};
    // shift by 64 leaves all ones in the mask
    assign keep_mask = ~({trace_cfg_pkg::XLEN{1'b1}} << addr_bits);
    assign trap_head = {thaddr_i, sel_interrupt_i, sel_cause_i, tc_priv_i, branch_bit_i};

    always_comb begin
        case (subformat_i)
            trace_pkt_pkg::SF_START: begin
                body_o      = {tc_iaddr_i & keep_mask, tc_priv_i, branch_bit_i};
                body_bits_o = trace_cfg_pkg::USED_BITS_LEN'(
                    1 + trace_cfg_pkg::PRIV_LEN + addr_bits);
            end
            trace_pkt_pkg::SF_TRAP: begin
                // full tval sits right after the kept trap address
                body_o      = {trap_addr_i & keep_mask, trap_head}
                            | (sel_tval_i << ($bits(trap_head) + addr_bits));
                body_bits_o = trace_cfg_pkg::USED_BITS_LEN'(
                    $bits(trap_head) + addr_bits + trace_cfg_pkg::XLEN);
            end
            trace_pkt_pkg::SF_CONTEXT: begin
                body_o      = tc_priv_i;
                body_bits_o = trace_cfg_pkg::USED_BITS_LEN'(trace_cfg_pkg::PRIV_LEN);
            end
            default: begin
                body_o      = {ioptions_i, qual_status_i, encoder_mode_i, tc_ienable_i};
                body_bits_o = trace_cfg_pkg::USED_BITS_LEN'(
                    $bits(ioptions_i) + $bits(qual_status_i) + 2);
            end
        endcase
    end

endmodule

//--- emitter/delta_field_builder.sv
// execute stage for formats 1 and 2, body starts above the 2 format bits
// owns the latest address register behind the differential address
module delta_field_builder (
    input  logic                                        clk_i,
    input  logic                                        rst_ni,
    input  logic                                        is_branch_map_i,
    input  logic                                        update_latest_i,
    input  logic [trace_cfg_pkg::XLEN-1:0]              tc_iaddr_i,
    input  logic                                        lc_updiscon_i,
    input  logic [trace_cfg_pkg::BRANCH_COUNT_LEN-1:0]  branches_i,
    input  logic [trace_cfg_pkg::BRANCH_MAP_LEN-1:0]    branch_map_i,
    input  logic [trace_cfg_pkg::KEEP_BYTES_LEN-1:0]    keep_bytes_i,
    output logic [trace_cfg_pkg::BODY_LEN-1:0]          body_o,
    output logic [trace_cfg_pkg::USED_BITS_LEN-1:0]     body_bits_o
);

    logic [trace_cfg_pkg::XLEN-1:0]          latest_q;
    logic [trace_cfg_pkg::XLEN-1:0]          diff_addr;
    logic [trace_cfg_pkg::XLEN-1:0]          keep_mask;
    logic [6:0]                              addr_bits;
    logic                                    notify;
    logic                                    updiscon;
    // irdepth, irreport, updiscon, notify
    logic [trace_cfg_pkg::IRDEPTH_LEN+2:0]   flag_grp;
    logic [5:0]                              map_bits;
    logic [trace_cfg_pkg::BODY_LEN-1:0]      addr_part;
    logic [trace_cfg_pkg::BODY_LEN-1:0]      map_part;

    // last address sent in a packet
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            latest_q <= '0;
        end else if (update_latest_i) begin
            latest_q <= tc_iaddr_i;
        end
    end

    assign diff_addr = tc_iaddr_i - latest_q;
    assign addr_bits = {keep_bytes_i, 3'b000};
    assign keep_mask = ~({trace_cfg_pkg::XLEN{1'b1}} << addr_bits);

    // no trigger unit, so notify just mirrors the address msb
    assign notify   = tc_iaddr_i[trace_cfg_pkg::XLEN-1];
    assign updiscon = lc_updiscon_i ? ~notify : notify;
    assign flag_grp = {{trace_cfg_pkg::IRDEPTH_LEN{updiscon}}, updiscon, updiscon, notify};

    // format 2 field group, also reused as the tail of format 1
    assign addr_part = (diff_addr & keep_mask) | (flag_grp << addr_bits);

    // smallest map size that holds the branch count
    always_comb begin
        if (branches_i == '0) begin
            map_bits = 6'd0;
        end else if (branches_i <= 5'd1) begin
            map_bits = 6'd1;
        end else if (branches_i <= 5'd9) begin
            map_bits = 6'd9;
        end else if (branches_i <= 5'd17) begin
            map_bits = 6'd17;
        end else if (branches_i <= 5'd25) begin
            map_bits = 6'd25;
        end else begin
            map_bits = 6'd31;
        end
    end

    assign map_part = {branch_map_i & ~({trace_cfg_pkg::BRANCH_MAP_LEN{1'b1}} << map_bits),
                       branches_i};

    always_comb begin
        if (!is_branch_map_i) begin
            body_o      = addr_part;
            body_bits_o = trace_cfg_pkg::USED_BITS_LEN'(addr_bits + $bits(flag_grp));
        end else if (branches_i < trace_cfg_pkg::BRANCH_MAP_LEN) begin
            body_o      = map_part | (addr_part << (trace_cfg_pkg::BRANCH_COUNT_LEN + map_bits));
            body_bits_o = trace_cfg_pkg::USED_BITS_LEN'(trace_cfg_pkg::BRANCH_COUNT_LEN
                        + map_bits + addr_bits + $bits(flag_grp));
        end else begin
            // full map, address not needed
            body_o      = map_part;
            body_bits_o = trace_cfg_pkg::USED_BITS_LEN'(trace_cfg_pkg::BRANCH_COUNT_LEN
                        + map_bits);
        end
    end

endmodule

//--- emitter/packet_assembler.sv
// result stage, puts the header under the body and registers the packet
// outputs are zero in any cycle after no packet was requested
module packet_assembler (
    input  logic                                     clk_i,
    input  logic                                     rst_ni,
    input  logic                                     emit_i,
    input  logic                                     flush_i,
    input  trace_pkt_pkg::packet_type_e              pkt_type_i,
    input  trace_pkt_pkg::format_e                   format_i,
    input  trace_pkt_pkg::sync_subformat_e           subformat_i,
    input  logic [trace_cfg_pkg::BODY_LEN-1:0]       sync_body_i,
    input  logic [trace_cfg_pkg::USED_BITS_LEN-1:0]  sync_bits_i,
    input  logic [trace_cfg_pkg::BODY_LEN-1:0]       delta_body_i,
    input  logic [trace_cfg_pkg::USED_BITS_LEN-1:0]  delta_bits_i,
    output logic                                     packet_valid_o,
    output trace_pkt_pkg::packet_type_e              packet_type_o,
    output logic [trace_cfg_pkg::PAYLOAD_LEN-1:0]    packet_payload_o,
    output logic [trace_cfg_pkg::P_LEN-1:0]          payload_length_o,
    output logic                                     branch_map_flush_o
);

    logic [trace_cfg_pkg::PAYLOAD_LEN-1:0]    payload_d;
    logic [trace_cfg_pkg::USED_BITS_LEN-1:0]  used_bits;
    logic [trace_cfg_pkg::USED_BITS_LEN-1:0]  byte_count;

    always_comb begin
        if (format_i == trace_pkt_pkg::F_SYNC) begin
            // format 3 also carries its subformat in bits 3:2
            payload_d = {sync_body_i, subformat_i, format_i};
            used_bits = sync_bits_i + 4'd4;
        end else begin
            payload_d = {delta_body_i, format_i};
            used_bits = delta_bits_i + 4'd2;
        end
    end

    // round up to whole bytes
    assign byte_count = (used_bits + 4'd7) >> 3;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            packet_valid_o     <= 1'b0;
            packet_type_o      <= trace_pkt_pkg::PT_NONE;
            packet_payload_o   <= '0;
            payload_length_o   <= '0;
            branch_map_flush_o <= 1'b0;
        end else if (emit_i) begin
            packet_valid_o     <= 1'b1;
            packet_type_o      <= pkt_type_i;
            packet_payload_o   <= payload_d;
            payload_length_o   <= byte_count[trace_cfg_pkg::P_LEN-1:0];
            branch_map_flush_o <= flush_i;
        end else begin
            packet_valid_o     <= 1'b0;
            packet_type_o      <= trace_pkt_pkg::PT_NONE;
            packet_payload_o   <= '0;
            payload_length_o   <= '0;
            branch_map_flush_o <= 1'b0;
        end
    end

endmodule

//--- emitter/trace_packet_emitter.sv
// trace packet emitter top, decode and build in one cycle then register
// a packet request on valid_i shows up on the outputs one cycle later
module trace_packet_emitter (
    input  logic                                        clk_i,
    input  logic                                        rst_ni,
    input  logic                                        valid_i,
    input  trace_pkt_pkg::format_e                      packet_format_i,
    input  trace_pkt_pkg::sync_subformat_e              packet_f_sync_subformat_i,
    input  logic [trace_cfg_pkg::CAUSE_LEN-1:0]         lc_cause_i,
    input  logic [trace_cfg_pkg::XLEN-1:0]              lc_tval_i,
    input  logic                                        lc_interrupt_i,
    input  logic [trace_cfg_pkg::CAUSE_LEN-1:0]         tc_cause_i,
    input  logic [trace_cfg_pkg::XLEN-1:0]              tc_tval_i,
    input  logic                                        tc_interrupt_i,
    input  logic                                        tc_branch_i,
    input  logic                                        tc_branch_taken_i,
    input  logic [trace_cfg_pkg::PRIV_LEN-1:0]          tc_priv_i,
    input  logic [trace_cfg_pkg::XLEN-1:0]              tc_iaddr_i,
    input  logic                                        lc_tc_mux_i,
    input  logic                                        thaddr_i,
    input  logic [trace_cfg_pkg::XLEN-1:2]              tc_tvec_i,
    input  logic [trace_cfg_pkg::XLEN-1:0]              lc_epc_i,
    input  logic                                        tc_ienable_i,
    input  logic                                        encoder_mode_i,
    input  trace_pkt_pkg::qual_status_e                 qual_status_i,
    input  trace_pkt_pkg::ioptions_e                    ioptions_i,
    input  logic                                        lc_updiscon_i,
    input  logic [trace_cfg_pkg::BRANCH_COUNT_LEN-1:0]  branches_i,
    input  logic [trace_cfg_pkg::BRANCH_MAP_LEN-1:0]    branch_map_i,
    input  logic [trace_cfg_pkg::KEEP_BITS_LEN-1:0]     keep_bits_i,
    output logic                                        packet_valid_o,
    output trace_pkt_pkg::packet_type_e                 packet_type_o,
    output logic [trace_cfg_pkg::PAYLOAD_LEN-1:0]       packet_payload_o,
    output logic [trace_cfg_pkg::P_LEN-1:0]             payload_length_o,
    output logic                                        branch_map_flush_o
);

    logic                                     emit, update_latest, flush, branch_bit;
    trace_pkt_pkg::packet_type_e              pkt_type;
    logic [trace_cfg_pkg::CAUSE_LEN-1:0]      sel_cause;
    logic [trace_cfg_pkg::XLEN-1:0]           sel_tval, trap_addr;
    logic                                     sel_interrupt;
    logic [trace_cfg_pkg::KEEP_BYTES_LEN-1:0] keep_bytes;
    logic [trace_cfg_pkg::BODY_LEN-1:0]       sync_body, delta_body;
    logic [trace_cfg_pkg::USED_BITS_LEN-1:0]  sync_bits, delta_bits;

    packet_decoder u_decoder (
        .valid_i, .packet_format_i, .packet_f_sync_subformat_i, .lc_tc_mux_i, .thaddr_i,
        .tc_branch_i, .tc_branch_taken_i, .lc_cause_i, .tc_cause_i, .lc_tval_i, .tc_tval_i,
        .lc_interrupt_i, .tc_interrupt_i, .tc_tvec_i, .lc_epc_i, .keep_bits_i,
        .emit_o(emit), .update_latest_o(update_latest), .flush_o(flush),
        .pkt_type_o(pkt_type), .branch_bit_o(branch_bit), .sel_cause_o(sel_cause),
        .sel_tval_o(sel_tval), .sel_interrupt_o(sel_interrupt), .trap_addr_o(trap_addr),
        .keep_bytes_o(keep_bytes)
    );

    sync_field_builder u_sync (
        .subformat_i(packet_f_sync_subformat_i), .branch_bit_i(branch_bit), .tc_priv_i,
        .tc_iaddr_i, .sel_cause_i(sel_cause), .sel_interrupt_i(sel_interrupt), .thaddr_i,
        .trap_addr_i(trap_addr), .sel_tval_i(sel_tval), .tc_ienable_i, .encoder_mode_i,
        .qual_status_i, .ioptions_i, .keep_bytes_i(keep_bytes),
        .body_o(sync_body), .body_bits_o(sync_bits)
    );

    // flush marks a format 1 request, which selects the branch map layout
    delta_field_builder u_delta (
        .clk_i, .rst_ni, .is_branch_map_i(flush), .update_latest_i(update_latest),
        .tc_iaddr_i, .lc_updiscon_i, .branches_i, .branch_map_i, .keep_bytes_i(keep_bytes),
        .body_o(delta_body), .body_bits_o(delta_bits)
    );

    packet_assembler u_assembler (
        .clk_i, .rst_ni, .emit_i(emit), .flush_i(flush), .pkt_type_i(pkt_type),
        .format_i(packet_format_i), .subformat_i(packet_f_sync_subformat_i),
        .sync_body_i(sync_body), .sync_bits_i(sync_bits),
        .delta_body_i(delta_body), .delta_bits_i(delta_bits),
        .packet_valid_o, .packet_type_o, .packet_payload_o, .payload_length_o,
        .branch_map_flush_o
    );

endmodule

//--- verif/tb_trace_packet_emitter.sv
// directed testbench for the trace packet emitter
// each test drives packets and compares outputs with a field packing model
module tb_trace_packet_emitter;

    localparam int TIMEOUT_CYCLES = 2000;

    logic clk;
    logic rst_n;
    logic valid, lc_interrupt, tc_interrupt, tc_branch, tc_branch_taken;
    logic lc_tc_mux, thaddr, tc_ienable, encoder_mode, lc_updiscon;
    trace_pkt_pkg::format_e          packet_format;
    trace_pkt_pkg::sync_subformat_e  packet_f_sync_subformat;
    trace_pkt_pkg::qual_status_e     qual_status;
    trace_pkt_pkg::ioptions_e        ioptions;
    logic [4:0]   lc_cause, tc_cause, branches;
    logic [63:0]  lc_tval, tc_tval, tc_iaddr, lc_epc;
    logic [63:2]  tc_tvec;
    logic [1:0]   tc_priv;
    logic [30:0]  branch_map;
    logic [6:0]   keep_bits;
    logic         packet_valid, branch_map_flush;
    trace_pkt_pkg::packet_type_e     packet_type;
    logic [143:0] packet_payload;
    logic [4:0]   payload_length;

    // expected response and model state
    logic [143:0] exp_pay;
    int           exp_pos;
    logic         exp_valid, exp_flush;
    logic [4:0]   exp_len;
    trace_pkt_pkg::packet_type_e     exp_type;
    logic [63:0]  model_latest;
    int           n_checks, n_errors, cycle_count;

    trace_packet_emitter u_trace_packet_emitter (
        .clk_i(clk), .rst_ni(rst_n), .valid_i(valid), .packet_format_i(packet_format),
        .packet_f_sync_subformat_i(packet_f_sync_subformat), .lc_cause_i(lc_cause),
        .lc_tval_i(lc_tval), .lc_interrupt_i(lc_interrupt), .tc_cause_i(tc_cause),
        .tc_tval_i(tc_tval), .tc_interrupt_i(tc_interrupt), .tc_branch_i(tc_branch),
        .tc_branch_taken_i(tc_branch_taken), .tc_priv_i(tc_priv), .tc_iaddr_i(tc_iaddr),
        .lc_tc_mux_i(lc_tc_mux), .thaddr_i(thaddr), .tc_tvec_i(tc_tvec), .lc_epc_i(lc_epc),
        .tc_ienable_i(tc_ienable), .encoder_mode_i(encoder_mode), .qual_status_i(qual_status),
        .ioptions_i(ioptions), .lc_updiscon_i(lc_updiscon), .branches_i(branches),
        .branch_map_i(branch_map), .keep_bits_i(keep_bits), .packet_valid_o(packet_valid),
        .packet_type_o(packet_type), .packet_payload_o(packet_payload),
        .payload_length_o(payload_length), .branch_map_flush_o(branch_map_flush)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // hard stop well beyond the few dozen cycles the tests need
    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout, run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("sim failed");
            $finish;
        end
    end

    function automatic logic [63:0] random_addr();
        return {$urandom, $urandom};
    endfunction

    // append a field above the bits used so far
    function automatic void put_field(logic [63:0] value, int width);
        for (int i = 0; i < width; i++) begin
            exp_pay[exp_pos+i] = value[i];
        end
        exp_pos += width;
    endfunction

    // map size is the smallest of 0, 1, 9, 17, 25, 31 that holds the count
    function automatic int map_size(int count);
        if (count <= 1) return count;
        if (count <= 9) return 9;
        if (count <= 17) return 17;
        if (count <= 25) return 25;
        return 31;
    endfunction

    // differential address then notify, updiscon, irreport, irdepth
    function automatic void put_addr_group(int kb);
        logic upd;
        upd = lc_updiscon ? ~tc_iaddr[63] : tc_iaddr[63];
        put_field(tc_iaddr - model_latest, 8 * kb);
        put_field(tc_iaddr[63], 1);
        put_field(upd, 1);
        put_field(upd, 1);
        put_field({8{upd}}, 8);
    endfunction

    function automatic void model_packet();
        int unsigned kb;
        logic        br;
        exp_pay   = '0;
        exp_pos   = 0;
        exp_type  = trace_pkt_pkg::PT_NONE;
        exp_flush = 1'b0;
        exp_len   = '0;
        exp_valid = valid && (packet_format != trace_pkt_pkg::F_OPT_EXT);
        if (!exp_valid) return;
        kb = (keep_bits + 7) / 8;
        if (kb > 8) kb = 8;
        br = !(tc_branch && tc_branch_taken);
        put_field(packet_format, 2);
        if (packet_format == trace_pkt_pkg::F_SYNC) begin
            put_field(packet_f_sync_subformat, 2);
            case (packet_f_sync_subformat)
                trace_pkt_pkg::SF_START: begin
                    exp_type = trace_pkt_pkg::PT_F3SF0;
                    put_field(br, 1);
                    put_field(tc_priv, 2);
                    put_field(tc_iaddr, 8 * kb);
                end
                trace_pkt_pkg::SF_TRAP: begin
                    exp_type = trace_pkt_pkg::PT_F3SF1;
                    put_field(br, 1);
                    put_field(tc_priv, 2);
                    put_field(lc_tc_mux ? tc_cause : lc_cause, 5);
                    put_field(lc_tc_mux ? tc_interrupt : lc_interrupt, 1);
                    put_field(thaddr, 1);
                    put_field(thaddr ? {tc_tvec, 2'b00} : lc_epc, 8 * kb);
                    put_field(lc_tc_mux ? tc_tval : lc_tval, 64);
                end
                trace_pkt_pkg::SF_CONTEXT: begin
                    exp_type = trace_pkt_pkg::PT_F3SF2;
                    put_field(tc_priv, 2);
                end
                default: begin
                    exp_type = trace_pkt_pkg::PT_F3SF3;
                    put_field(tc_ienable, 1);
                    put_field(encoder_mode, 1);
                    put_field(qual_status, 2);
                    put_field(ioptions, 3);
                end
            endcase
        end else if (packet_format == trace_pkt_pkg::F_ADDR_ONLY) begin
            exp_type = trace_pkt_pkg::PT_F2;
            put_addr_group(kb);
        end else begin
            exp_type  = trace_pkt_pkg::PT_F1;
            exp_flush = 1'b1;
            put_field(branches, 5);
            put_field(branch_map, map_size(branches));
            if (branches < 31) put_addr_group(kb);
        end
        exp_len = 5'((exp_pos + 7) / 8);
        // context and support leave the latest address alone
        if (packet_format != trace_pkt_pkg::F_SYNC ||
            packet_f_sync_subformat inside {trace_pkt_pkg::SF_START, trace_pkt_pkg::SF_TRAP})
            model_latest = tc_iaddr;
    endfunction

    task automatic report(input string name, input string sig, input logic [143:0] got,
                          input logic [143:0] exp);
        $display("MISMATCH %s %s got %h exp %h", name, sig, got, exp);
        n_errors++;
    endtask

    task automatic check_outputs(input string name);
        n_checks++;
        if (packet_valid !== exp_valid) report(name, "packet_valid_o", packet_valid, exp_valid);
        if (packet_type !== exp_type) report(name, "packet_type_o", packet_type, exp_type);
        if (packet_payload !== exp_pay) report(name, "packet_payload_o", packet_payload, exp_pay);
        if (payload_length !== exp_len) report(name, "payload_length_o", payload_length, exp_len);
        if (branch_map_flush !== exp_flush)
            report(name, "branch_map_flush_o", branch_map_flush, exp_flush);
    endtask

    // called at one unit past an edge, returns one cycle later at the same phase
    task automatic send_packet(input logic vld, input trace_pkt_pkg::format_e fmt,
                               input trace_pkt_pkg::sync_subformat_e sf, input string name);
        valid                   = vld;
        packet_format           = fmt;
        packet_f_sync_subformat = sf;
        model_packet();
        @(posedge clk);
        #1;
        check_outputs(name);
    endtask

    task automatic test_reset();
        model_packet();
        check_outputs("reset");
        send_packet(1'b0, trace_pkt_pkg::F_SYNC, trace_pkt_pkg::SF_START, "valid low");
        send_packet(1'b1, trace_pkt_pkg::F_OPT_EXT, trace_pkt_pkg::SF_START, "format 0");
    endtask

    task automatic test_start();
        int keeps[5] = '{0, 7, 10, 25, 64};
        foreach (keeps[i]) begin
            keep_bits = 7'(keeps[i]);
            tc_iaddr  = random_addr();
            // walk every branch and taken combination
            tc_branch       = 1'(i / 2);
            tc_branch_taken = 1'(i);
            tc_priv   = 2'($urandom);
            send_packet(1'b1, trace_pkt_pkg::F_SYNC, trace_pkt_pkg::SF_START, "start");
            // 7 fixed bits plus whole kept bytes
            if (payload_length !== 5'((keeps[i] + 7) / 8 + 1))
                report("start", "payload_length_o", payload_length, (keeps[i] + 7) / 8 + 1);
        end
    endtask

    task automatic test_trap();
        for (int m = 0; m < 2; m++) begin
            for (int t = 0; t < 2; t++) begin
                lc_tc_mux = 1'(m);
                thaddr    = 1'(t);
                keep_bits = t ? 7'd64 : 7'd24;
                lc_cause  = 5'($urandom);
                tc_cause  = 5'($urandom);
                lc_tval   = random_addr();
                tc_tval   = random_addr();
                // lc and tc interrupt always differ
                lc_interrupt = 1'(t);
                tc_interrupt = 1'(~t);
                tc_tvec   = 62'(random_addr());
                lc_epc    = random_addr();
                tc_iaddr  = random_addr();
                send_packet(1'b1, trace_pkt_pkg::F_SYNC, trace_pkt_pkg::SF_TRAP, "trap");
            end
        end
    endtask

    task automatic test_context_support();
        tc_priv      = 2'd3;
        tc_ienable   = 1'b1;
        encoder_mode = 1'b0;
        qual_status  = trace_pkt_pkg::QS_TRACE_LOST;
        ioptions     = trace_pkt_pkg::IO_IMPLICIT_RET;
        send_packet(1'b1, trace_pkt_pkg::F_SYNC, trace_pkt_pkg::SF_CONTEXT, "context");
        if (payload_length !== 5'd1) report("context", "payload_length_o", payload_length, 1);
        send_packet(1'b1, trace_pkt_pkg::F_SYNC, trace_pkt_pkg::SF_SUPPORT, "support");
        if (payload_length !== 5'd2) report("support", "payload_length_o", payload_length, 2);
    endtask

    task automatic test_addr_only();
        keep_bits = 7'd64;
        tc_iaddr  = random_addr();
        send_packet(1'b1, trace_pkt_pkg::F_SYNC, trace_pkt_pkg::SF_START, "start before f2");
        for (int u = 0; u < 2; u++) begin
            for (int top = 0; top < 2; top++) begin
                lc_updiscon  = 1'(u);
                keep_bits    = u ? 7'd40 : 7'd64;
                tc_iaddr     = random_addr();
                tc_iaddr[63] = 1'(top);
                send_packet(1'b1, trace_pkt_pkg::F_ADDR_ONLY, trace_pkt_pkg::SF_START, "f2");
            end
        end
    endtask

    task automatic test_branch_map();
        int counts[5] = '{0, 1, 5, 20, 31};
        keep_bits = 7'd33;
        foreach (counts[i]) begin
            branches    = 5'(counts[i]);
            branch_map  = 31'($urandom);
            tc_iaddr    = random_addr();
            lc_updiscon = 1'(i);
            send_packet(1'b1, trace_pkt_pkg::F_DIFF_DELTA, trace_pkt_pkg::SF_START, "f1");
        end
        send_packet(1'b0, trace_pkt_pkg::F_DIFF_DELTA, trace_pkt_pkg::SF_START, "idle");
    endtask

    initial begin
        void'($urandom(78265));
        rst_n = 1'b0;
        valid = 1'b0;
        packet_format = trace_pkt_pkg::F_OPT_EXT;
        packet_f_sync_subformat = trace_pkt_pkg::SF_START;
        qual_status = trace_pkt_pkg::QS_NO_CHANGE;
        ioptions = trace_pkt_pkg::IO_DELTA_ADDR;
        {lc_interrupt, tc_interrupt, tc_branch, tc_branch_taken} = '0;
        {lc_tc_mux, thaddr, tc_ienable, encoder_mode, lc_updiscon} = '0;
        {lc_cause, tc_cause, branches, tc_priv, branch_map, keep_bits} = '0;
        {lc_tval, tc_tval, tc_iaddr, lc_epc, tc_tvec} = '0;
        model_latest = '0;
        n_checks = 0;
        n_errors = 0;
        cycle_count = 0;
        repeat (5) @(posedge clk);
        #1;
        rst_n = 1'b1;
        test_reset();
        test_start();
        test_trap();
        test_context_support();
        test_addr_only();
        test_branch_map();
        $display("checks %0d, errors %0d", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

//--- vlog.f
common/trace_cfg_pkg.sv
common/trace_pkt_pkg.sv
emitter/packet_decoder.sv
emitter/sync_field_builder.sv
emitter/delta_field_builder.sv
emitter/packet_assembler.sv
emitter/trace_packet_emitter.sv
verif/tb_trace_packet_emitter.sv

//--- Makefile
# Verilator build and run of the trace packet emitter testbench

VERILATOR ?= verilator
TOP       ?= tb_trace_packet_emitter
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^sim passed$$" $(LOG) || (echo "simulation did not pass" && exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
